//--- Bender.yml
package:
  name: rob_subsystem

sources:
  - include_dirs:
      - source
    files:
      - source/rob_pkg.sv
      - source/rob_ctrl.sv
      - source/rob_entry_array.sv
      - source/commit_fifo.sv
      - source/arch_reg_file.sv
      - source/rob_top.sv
  - target: simulation
    include_dirs:
      - source
    files:
      - dv/rob_sva.sv
      - dv/tb_rob.sv

//--- dv/rob_sva.sv
`default_nettype none

`include "rob_params.svh"

module rob_sva (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic                   stall,
    input  logic [`ROB_IDX_W-1:0]  head_idx,
    input  logic [`ROB_IDX_W-1:0]  tail_idx,
    input  logic                   free_req,
    input  logic                   free_ack,
    input  rob_pkg::free_reg_t     free_reg,
    input  logic                   store_req,
    input  logic                   store_ack,
    input  rob_pkg::store_commit_t store_commit
);
    timeunit 1ns;
    timeprecision 1ps;

    // pointers apart means free entries remain
    stall_only_when_full: assert property (@(posedge clk) disable iff (!rstn)
        (tail_idx != head_idx) |-> !stall)
        else $error("stall high with free rob entries");

    // phase 5 allows a new req only after ack was seen low
    free_req_after_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(free_req) |-> !$past(free_ack))
        else $error("free_req rose while free_ack high");

    store_req_after_ack_low: assert property (@(posedge clk) disable iff (!rstn)
        $rose(store_req) |-> !$past(store_ack))
        else $error("store_req rose while store_ack high");

    free_payload_stable: assert property (@(posedge clk) disable iff (!rstn)
        (free_req && $past(free_req)) |-> $stable(free_reg))
        else $error("free_reg changed under free_req");

    store_payload_stable: assert property (@(posedge clk) disable iff (!rstn)
        (store_req && $past(store_req)) |-> $stable(store_commit))
        else $error("store_commit changed under store_req");

endmodule

`default_nettype wire

//--- dv/tb_rob.sv
`default_nettype none

`include "rob_params.svh"

module tb_rob;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT = 400;   // cycles per wait

    logic                   clk;
    logic                   rstn;
    logic                   dispatch_valid;
    rob_pkg::dispatch_t     dispatch;
    logic                   stall;
    rob_pkg::complete_t     complete_0;
    rob_pkg::complete_t     complete_1;
    logic                   free_req;
    logic                   free_ack;
    rob_pkg::free_reg_t     free_reg;
    logic                   store_req;
    logic                   store_ack;
    rob_pkg::store_commit_t store_commit;
    logic [`ARCH_W-1:0]     arch_rd_idx;
    logic [`DATA_W-1:0]     arch_rd_data;

    //////////////////////////////
    // scoreboard state
    //////////////////////////////
    rob_pkg::dispatch_t     pend_instr [$];   // program order
    logic [`ROB_IDX_W-1:0]  pend_idx [$];
    logic [`DATA_W-1:0]     pend_val [$];
    rob_pkg::free_reg_t     exp_free [$];
    rob_pkg::free_reg_t     got_free [$];
    rob_pkg::store_commit_t exp_store [$];
    rob_pkg::store_commit_t got_store [$];
    logic [`DATA_W-1:0]     exp_arf [2**`ARCH_W];
    logic [`ROB_IDX_W-1:0]  tail;             // model of the dut tail
    logic                   free_hold;        // withhold free_ack
    integer                 seed = 32'ha606_6077;
    int                     errors;
    int                     checks;
    int                     tests;

    rob_top dut_i (.*);

    bind rob_top rob_sva sva_i (
        .clk, .rstn, .stall, .head_idx, .tail_idx,
        .free_req, .free_ack, .free_reg, .store_req, .store_ack, .store_commit
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // four-phase consumers that move ack 2 ns after the edge
    initial begin
        free_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (free_req && !free_ack && !free_hold) begin
                got_free.push_back(free_reg);
                free_ack = 1'b1;
            end else if (!free_req && free_ack) begin
                free_ack = 1'b0;
            end
        end
    end

    initial begin
        store_ack = 1'b0;
        forever begin
            @(posedge clk);
            #2;
            if (store_req && !store_ack) begin
                got_store.push_back(store_commit);
                store_ack = 1'b1;
            end else if (!store_req && store_ack) begin
                store_ack = 1'b0;
            end
        end
    end

    //////////////////////////////
    // helpers
    //////////////////////////////
    task automatic step();
        @(posedge clk);
        #1;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("timeout at %0t while waiting for %s", $time, what);
        $display("TEST FAIL");
        $finish;
    endtask

    task automatic compare_word(input string name, input logic [`DATA_W-1:0] got,
                                input logic [`DATA_W-1:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%h exp=%h", $time, name, got, exp);
        end
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=%b exp=%b", $time, name, got, exp);
        end
    endtask

    task automatic compare_free(input string name, input rob_pkg::free_reg_t got,
                                input rob_pkg::free_reg_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=phys %h arch %h exp=phys %h arch %h",
                     $time, name, got.phys, got.arch, exp.phys, exp.arch);
        end
    endtask

    task automatic compare_store(input string name, input rob_pkg::store_commit_t got,
                                 input rob_pkg::store_commit_t exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("MISMATCH t=%0t %s got=addr %h data %h exp=addr %h data %h",
                     $time, name, got.addr, got.data, exp.addr, exp.data);
        end
    endtask

    function automatic rob_pkg::dispatch_t make_instr(input logic is_store,
                                                      input logic [`ARCH_W-1:0] arch);
        rob_pkg::dispatch_t d;
        d.arch_dst = arch;
        d.phys_dst = `PHYS_W'($random(seed));
        d.old_phys = `PHYS_W'($random(seed));
        d.is_store = is_store;
        d.st_addr  = $random(seed);
        d.st_data  = $random(seed);
        return d;
    endfunction

    // youngest occupant of the slot gets the result
    function automatic void set_result(input logic [`ROB_IDX_W-1:0] idx,
                                       input logic [`DATA_W-1:0] v);
        for (int i = pend_idx.size() - 1; i >= 0; i--) begin
            if (pend_idx[i] == idx) begin
                pend_val[i] = v;
                return;
            end
        end
    endfunction

    // holds dispatch until a cycle with stall low
    task automatic wait_accept(output logic [`ROB_IDX_W-1:0] idx);
        int   n;
        logic took;
        n    = 0;
        took = 1'b0;
        while (!took) begin
            if (n == TIMEOUT)
                stop_on_timeout("dispatch to be accepted");
            took = !stall;
            step();
            n++;
        end
        dispatch_valid = 1'b0;
        idx = tail;
        pend_instr.push_back(dispatch);
        pend_idx.push_back(tail);
        pend_val.push_back('0);
        if (dispatch.is_store)
            exp_store.push_back('{addr: dispatch.st_addr, data: dispatch.st_data});
        else
            exp_free.push_back('{phys: dispatch.old_phys, arch: dispatch.arch_dst});
        tail = tail + 1'b1;
    endtask

    task automatic dispatch_one(input rob_pkg::dispatch_t d,
                                output logic [`ROB_IDX_W-1:0] idx);
        dispatch_valid = 1'b1;
        dispatch       = d;
        wait_accept(idx);
    endtask

    task automatic complete_pair(input logic [`ROB_IDX_W-1:0] idx0, input logic two,
                                 input logic [`ROB_IDX_W-1:0] idx1);
        logic [`DATA_W-1:0] v0;
        logic [`DATA_W-1:0] v1;
        v0 = $random(seed);
        v1 = $random(seed);
        complete_0 = '{valid: 1'b1, idx: idx0, value: v0};
        complete_1 = '{valid: two, idx: idx1, value: v1};
        set_result(idx0, v0);
        if (two)
            set_result(idx1, v1);
        step();
        complete_0 = '0;
        complete_1 = '0;
    endtask

    task automatic check_arf();
        for (int r = 0; r < 2**`ARCH_W; r++) begin
            arch_rd_idx = `ARCH_W'(r);
            #10;
            compare_word($sformatf("arch_rd_data[%0d]", r), arch_rd_data, exp_arf[r]);
            step();
        end
    endtask

    // drain both streams then settle the model and compare
    task automatic finish_test(input string name, input int err0);
        int n;
        n = 0;
        while (got_free.size() < exp_free.size() || got_store.size() < exp_store.size()) begin
            if (n == TIMEOUT)
                stop_on_timeout("commit stream records");
            step();
            n++;
        end
        repeat (8) step();   // room for a duplicate to show up
        foreach (pend_instr[i]) begin
            if (!pend_instr[i].is_store)
                exp_arf[pend_instr[i].arch_dst] = pend_val[i];
        end
        if (got_free.size() != exp_free.size() || got_store.size() != exp_store.size()) begin
            errors++;
            $display("%s: wrong record count, free %0d of %0d, store %0d of %0d", name,
                     got_free.size(), exp_free.size(), got_store.size(), exp_store.size());
        end
        while (got_free.size() > 0 && exp_free.size() > 0)
            compare_free("free_reg", got_free.pop_front(), exp_free.pop_front());
        while (got_store.size() > 0 && exp_store.size() > 0)
            compare_store("store_commit", got_store.pop_front(), exp_store.pop_front());
        check_arf();
        pend_instr.delete();
        pend_idx.delete();
        pend_val.delete();
        got_free.delete();
        exp_free.delete();
        got_store.delete();
        exp_store.delete();
        tests++;
        $display("[%0t] %s finished with %0d errors", $time, name, errors - err0);
    endtask

    //////////////////////////////
    // directed tests
    //////////////////////////////
    task automatic test_reset_state();
        int err0;
        err0 = errors;
        compare_flag("stall", stall, 1'b0);
        compare_flag("free_req", free_req, 1'b0);
        compare_flag("store_req", store_req, 1'b0);
        finish_test("reset_state", err0);
    endtask

    task automatic test_ooo_retire();
        logic [`ROB_IDX_W-1:0] idx [8];
        int                    err0;
        err0 = errors;
        for (int i = 0; i < 8; i++)
            dispatch_one(make_instr(1'b0, `ARCH_W'(1 + i % 5)), idx[i]);   // regs 1..3 twice
        for (int i = 7; i > 0; i -= 2)
            complete_pair(idx[i], 1'b1, idx[i-1]);
        finish_test("ooo_retire", err0);
    endtask

    task automatic test_stores();
        logic [`ROB_IDX_W-1:0] idx [8];
        int                    err0;
        err0 = errors;
        for (int i = 0; i < 8; i++)
            dispatch_one(make_instr(i[0], `ARCH_W'(8 + i)), idx[i]);   // odd slots are stores
        complete_pair(idx[2], 1'b1, idx[5]);
        complete_pair(idx[7], 1'b1, idx[0]);
        complete_pair(idx[4], 1'b1, idx[1]);
        complete_pair(idx[6], 1'b1, idx[3]);
        finish_test("stores", err0);
    endtask

    task automatic test_same_reg();
        logic [`ROB_IDX_W-1:0] idx [2];
        int                    err0;
        err0 = errors;
        dispatch_one(make_instr(1'b0, `ARCH_W'(20)), idx[0]);
        dispatch_one(make_instr(1'b0, `ARCH_W'(20)), idx[1]);
        complete_pair(idx[0], 1'b1, idx[1]);
        finish_test("same_reg", err0);
    endtask

    task automatic test_full_stall();
        logic [`ROB_IDX_W-1:0] idx [33];
        int                    err0;
        err0 = errors;
        for (int i = 0; i < 32; i++)
            dispatch_one(make_instr(1'b0, `ARCH_W'(i)), idx[i]);
        compare_flag("stall", stall, 1'b1);
        dispatch       = make_instr(1'b0, `ARCH_W'(31));
        dispatch_valid = 1'b1;
        repeat (3) begin
            step();
            compare_flag("stall", stall, 1'b1);
        end
        complete_pair(idx[0], 1'b0, idx[0]);
        wait_accept(idx[32]);
        for (int i = 1; i < 33; i += 2)
            complete_pair(idx[i], 1'b1, idx[i+1]);
        finish_test("full_stall", err0);
    endtask

    task automatic test_backpressure();
        logic [`ROB_IDX_W-1:0] idx [8];
        int                    err0;
        err0      = errors;
        free_hold = 1'b1;
        for (int i = 0; i < 8; i++)
            dispatch_one(make_instr(1'b0, `ARCH_W'(24 + i)), idx[i]);
        for (int i = 0; i < 8; i += 2)
            complete_pair(idx[i], 1'b1, idx[i+1]);
        repeat (12) step();
        if (got_free.size() != 0) begin
            errors++;
            $display("free records delivered while free_ack was withheld");
        end
        compare_flag("free_req", free_req, 1'b1);
        // the queue holds four so only the oldest four writers retired
        arch_rd_idx = `ARCH_W'(27);
        #10;
        compare_word("arch_rd_data[27]", arch_rd_data, pend_val[3]);
        step();
        arch_rd_idx = `ARCH_W'(28);
        #10;
        compare_word("arch_rd_data[28]", arch_rd_data, exp_arf[28]);
        step();
        free_hold = 1'b0;
        finish_test("backpressure", err0);
    endtask

    initial begin
        rstn           = 1'b0;
        dispatch_valid = 1'b0;
        dispatch       = '0;
        complete_0     = '0;
        complete_1     = '0;
        arch_rd_idx    = '0;
        free_hold      = 1'b0;
        tail           = '0;
        errors         = 0;
        checks         = 0;
        tests          = 0;
        for (int r = 0; r < 2**`ARCH_W; r++)
            exp_arf[r] = '0;
        repeat (10) @(posedge clk);
        #1;
        rstn = 1'b1;

        test_reset_state();
        test_ooo_retire();
        test_stores();
        test_same_reg();
        test_full_stall();
        test_backpressure();

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0)
            $display("TEST PASS");
        else
            $display("TEST FAIL");
        $finish;
    end

endmodule

`default_nettype wire

//--- source/arch_reg_file.sv
`default_nettype none

`include "rob_params.svh"

module arch_reg_file (
    input  logic                               clk,
    input  logic                               rstn,
    input  rob_pkg::arf_wr_t [`RETIRE_W-1:0]   arf_wr,
    input  logic [`ARCH_W-1:0]                 rd_idx,
    output logic [`DATA_W-1:0]                 rd_data
);
    logic [`DATA_W-1:0] regs [2**`ARCH_W];

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            for (int i = 0; i < 2**`ARCH_W; i++)
                regs[i] <= '0;
        end else begin
            // ports never collide, ctrl merges same-target writes
            for (int p = 0; p < `RETIRE_W; p++) begin
                if (arf_wr[p].en)
                    regs[arf_wr[p].idx] <= arf_wr[p].data;
            end
        end
    end

    assign rd_data = regs[rd_idx];   // async read

endmodule

`default_nettype wire

//--- source/commit_fifo.sv
`default_nettype none

`include "rob_params.svh"

module commit_fifo #(
    parameter type payload_t = logic
) (
    input  logic       clk,
    input  logic       rstn,
    input  logic [1:0] push,
    input  payload_t   push_data_0,
    input  payload_t   push_data_1,
    output logic [2:0] room,
    output logic       req,
    input  logic       ack,
    output payload_t   data
);
    localparam int              PTR_W   = $clog2(`CQ_DEPTH);
    localparam int              CNT_W   = PTR_W + 1;
    localparam logic [CNT_W-1:0] DEPTH_C = CNT_W'(`CQ_DEPTH);

    payload_t          mem [`CQ_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  wr_ptr_1;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              ack_wait;    // req dropped, waiting on ack low
    logic              pop;

    assign room     = DEPTH_C - count;
    assign data     = mem[rd_ptr];      // stable while req is up
    assign pop      = ack_wait && !ack;
    assign wr_ptr_1 = wr_ptr + PTR_W'(push[0]);   // second push packs behind the first

    always_ff @(posedge clk) begin
        if (push[0])
            mem[wr_ptr] <= push_data_0;
        if (push[1])
            mem[wr_ptr_1] <= push_data_1;
    end

    //////////////////////////////
    // pointers and handshake
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            req      <= 1'b0;
            ack_wait <= 1'b0;
        end else begin
            wr_ptr <= wr_ptr + PTR_W'(push[0]) + PTR_W'(push[1]);
            count  <= count + CNT_W'(push[0]) + CNT_W'(push[1]) - CNT_W'(pop);
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;

            if (req && ack) begin
                req      <= 1'b0;               // phase 3
                ack_wait <= 1'b1;
            end else if (pop) begin
                ack_wait <= 1'b0;               // item gone on ack fall
            end else if (!req && !ack_wait && !ack && count != '0) begin
                req      <= 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

//--- source/rob_ctrl.sv
`default_nettype none

`include "rob_params.svh"

module rob_ctrl (
    input  logic                                  clk,
    input  logic                                  rstn,
    input  logic                                  dispatch_valid,
    input  rob_pkg::rob_entry_t                   head_entry_0,
    input  rob_pkg::rob_entry_t                   head_entry_1,
    input  logic [2:0]                            free_room,
    input  logic [2:0]                            store_room,
    output logic                                  stall,
    output logic                                  wr_en,
    output logic [`ROB_IDX_W-1:0]                 tail_idx,
    output logic [`ROB_IDX_W-1:0]                 head_idx,
    output logic [1:0]                            retire_cnt,
    output rob_pkg::arf_wr_t [`RETIRE_W-1:0]      arf_wr,
    output logic [1:0]                            free_push,
    output rob_pkg::free_reg_t                    free_data_0,
    output rob_pkg::free_reg_t                    free_data_1,
    output logic [1:0]                            store_push,
    output rob_pkg::store_commit_t                store_data_0,
    output rob_pkg::store_commit_t                store_data_1
);
    localparam int IDX_W = `ROB_IDX_W;
    localparam int OCC_W = `ROB_IDX_W + 1;

    logic [OCC_W-1:0] occupancy;
    logic             ret_0;
    logic             ret_1;
    logic             same_q;     // both heads go to the same queue
    logic [2:0]       room_1;

    assign stall = (occupancy == OCC_W'(`ROB_DEPTH));
    assign wr_en = dispatch_valid && !stall;

    //////////////////////////////
    // retire selection
    //////////////////////////////
    assign ret_0 = (occupancy != '0) && head_entry_0.done &&
                   (head_entry_0.instr.is_store ? (store_room != 3'd0) : (free_room != 3'd0));

    assign same_q = (head_entry_1.instr.is_store == head_entry_0.instr.is_store);
    assign room_1 = head_entry_1.instr.is_store ? store_room : free_room;

    // second one needs a slot left over after the first push
    assign ret_1 = ret_0 && (occupancy > OCC_W'(1)) && head_entry_1.done &&
                   (room_1 > (same_q ? 3'd1 : 3'd0));

    assign retire_cnt = {1'b0, ret_0} + {1'b0, ret_1};

    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            head_idx  <= '0;
            tail_idx  <= '0;
            occupancy <= '0;
        end else begin
            if (wr_en)
                tail_idx <= tail_idx + 1'b1;   // wraps with the index width
            head_idx  <= head_idx + IDX_W'(retire_cnt);
            occupancy <= occupancy + OCC_W'(wr_en) - OCC_W'(retire_cnt);
        end
    end

    //////////////////////////////
    // routing of retired entries
    //////////////////////////////
    assign free_push  = {ret_1 && !head_entry_1.instr.is_store, ret_0 && !head_entry_0.instr.is_store};
    assign store_push = {ret_1 && head_entry_1.instr.is_store, ret_0 && head_entry_0.instr.is_store};

    assign free_data_0  = '{phys: head_entry_0.instr.old_phys, arch: head_entry_0.instr.arch_dst};
    assign free_data_1  = '{phys: head_entry_1.instr.old_phys, arch: head_entry_1.instr.arch_dst};
    assign store_data_0 = '{addr: head_entry_0.instr.st_addr, data: head_entry_0.instr.st_data};
    assign store_data_1 = '{addr: head_entry_1.instr.st_addr, data: head_entry_1.instr.st_data};

    always_comb begin
        arf_wr = '0;
        if (free_push == 2'b11 && head_entry_0.instr.arch_dst == head_entry_1.instr.arch_dst) begin
            // same target, younger value wins
            arf_wr[0].en   = 1'b1;
            arf_wr[0].idx  = head_entry_1.instr.arch_dst;
            arf_wr[0].data = head_entry_1.result;
        end else begin
            arf_wr[0].en   = free_push[0];
            arf_wr[0].idx  = head_entry_0.instr.arch_dst;
            arf_wr[0].data = head_entry_0.result;
            arf_wr[1].en   = free_push[1];
            arf_wr[1].idx  = head_entry_1.instr.arch_dst;
            arf_wr[1].data = head_entry_1.result;
        end
    end

endmodule

`default_nettype wire

//--- source/rob_entry_array.sv
`default_nettype none

`include "rob_params.svh"

module rob_entry_array (
    input  logic                     clk,
    input  logic                     rstn,
    input  logic                     wr_en,
    input  logic [`ROB_IDX_W-1:0]    tail_idx,
    input  rob_pkg::dispatch_t       dispatch,
    input  rob_pkg::complete_t       complete_0,
    input  rob_pkg::complete_t       complete_1,
    input  logic [`ROB_IDX_W-1:0]    head_idx,
    input  logic [1:0]               retire_cnt,
    output rob_pkg::rob_entry_t      head_entry_0,
    output rob_pkg::rob_entry_t      head_entry_1
);
    rob_pkg::dispatch_t     instr_mem  [`ROB_DEPTH];
    logic [`DATA_W-1:0]     result_mem [`ROB_DEPTH];
    logic [`ROB_DEPTH-1:0]  done_q;

    logic [`ROB_IDX_W-1:0]  head_idx_1;   // second head slot

    assign head_idx_1 = head_idx + 1'b1;

    //////////////////////////////
    // done flags
    //////////////////////////////
    always_ff @(posedge clk or negedge rstn) begin
        if (!rstn) begin
            done_q <= '0;
        end else begin
            // free the slots that leave this cycle
            if (retire_cnt != 2'd0)
                done_q[head_idx] <= 1'b0;
            if (retire_cnt == 2'd2)
                done_q[head_idx_1] <= 1'b0;

            if (wr_en)
                done_q[tail_idx] <= 1'b0;     // new entry waits for its result

            if (complete_0.valid)
                done_q[complete_0.idx] <= 1'b1;
            if (complete_1.valid)
                done_q[complete_1.idx] <= 1'b1;
        end
    end

    //////////////////////////////
    // payload storage
    //////////////////////////////
    always_ff @(posedge clk) begin
        if (wr_en)
            instr_mem[tail_idx] <= dispatch;
    end

    // tags never collide, so both ports write freely
    always_ff @(posedge clk) begin
        if (complete_0.valid)
            result_mem[complete_0.idx] <= complete_0.value;
        if (complete_1.valid)
            result_mem[complete_1.idx] <= complete_1.value;
    end

    // head reads, combinational
    always_comb begin
        head_entry_0.instr  = instr_mem[head_idx];
        head_entry_0.done   = done_q[head_idx];
        head_entry_0.result = result_mem[head_idx];

        head_entry_1.instr  = instr_mem[head_idx_1];
        head_entry_1.done   = done_q[head_idx_1];
        head_entry_1.result = result_mem[head_idx_1];
    end

endmodule

`default_nettype wire

//--- source/rob_params.svh
`ifndef ROB_PARAMS_SVH
`define ROB_PARAMS_SVH

// reorder buffer sizing, depth must stay a power of two
`define ROB_DEPTH 32
`define ROB_IDX_W 5

// register and data widths
`define PHYS_W    6
`define ARCH_W    5
`define DATA_W    32

`define RETIRE_W  2   // entries retired per cycle at most
`define CQ_DEPTH  4   // slots in each commit queue

`endif

//--- source/rob_pkg.sv
`default_nettype none

`include "rob_params.svh"

package rob_pkg;

    // one instruction as handed over by rename
    typedef struct packed {
        logic [`ARCH_W-1:0] arch_dst;   // architectural destination
        logic [`PHYS_W-1:0] phys_dst;   // newly mapped tag
        logic [`PHYS_W-1:0] old_phys;   // previous mapping, freed at retire
        logic               is_store;
        logic [`DATA_W-1:0] st_addr;
        logic [`DATA_W-1:0] st_data;
    } dispatch_t;

    typedef struct packed {
        logic                  valid;
        logic [`ROB_IDX_W-1:0] idx;     // rob slot of the result
        logic [`DATA_W-1:0]    value;
    } complete_t;

    typedef struct packed {
        dispatch_t          instr;
        logic               done;
        logic [`DATA_W-1:0] result;
    } rob_entry_t;

    typedef struct packed {
        logic               en;
        logic [`ARCH_W-1:0] idx;
        logic [`DATA_W-1:0] data;
    } arf_wr_t;

    // free list record
    typedef struct packed {
        logic [`PHYS_W-1:0] phys;
        logic [`ARCH_W-1:0] arch;
    } free_reg_t;

    typedef struct packed {
        logic [`DATA_W-1:0] addr;
        logic [`DATA_W-1:0] data;
    } store_commit_t;

endpackage

`default_nettype wire

//--- source/rob_top.sv
`default_nettype none

`include "rob_params.svh"

module rob_top (
    input  logic                       clk,
    input  logic                       rstn,
    input  logic                       dispatch_valid,
    input  rob_pkg::dispatch_t         dispatch,
    output logic                       stall,
    input  rob_pkg::complete_t         complete_0,
    input  rob_pkg::complete_t         complete_1,
    output logic                       free_req,
    input  logic                       free_ack,
    output rob_pkg::free_reg_t         free_reg,
    output logic                       store_req,
    input  logic                       store_ack,
    output rob_pkg::store_commit_t     store_commit,
    input  logic [`ARCH_W-1:0]         arch_rd_idx,
    output logic [`DATA_W-1:0]         arch_rd_data
);
    logic                              wr_en;
    logic [`ROB_IDX_W-1:0]             tail_idx;
    logic [`ROB_IDX_W-1:0]             head_idx;
    logic [1:0]                        retire_cnt;
    rob_pkg::rob_entry_t               head_entry_0;
    rob_pkg::rob_entry_t               head_entry_1;
    rob_pkg::arf_wr_t [`RETIRE_W-1:0]  arf_wr;
    logic [2:0]                        free_room;
    logic [2:0]                        store_room;
    logic [1:0]                        free_push;
    logic [1:0]                        store_push;
    rob_pkg::free_reg_t                free_data_0;
    rob_pkg::free_reg_t                free_data_1;
    rob_pkg::store_commit_t            store_data_0;
    rob_pkg::store_commit_t            store_data_1;

    //////////////////////////////
    // control and entry storage
    //////////////////////////////
    rob_ctrl ctrl_i (
        .clk, .rstn, .dispatch_valid, .head_entry_0, .head_entry_1,
        .free_room, .store_room, .stall, .wr_en, .tail_idx, .head_idx,
        .retire_cnt, .arf_wr, .free_push, .free_data_0, .free_data_1,
        .store_push, .store_data_0, .store_data_1
    );

    rob_entry_array entries_i (
        .clk, .rstn, .wr_en, .tail_idx, .dispatch, .complete_0, .complete_1,
        .head_idx, .retire_cnt, .head_entry_0, .head_entry_1
    );

    arch_reg_file arf_i (
        .clk, .rstn, .arf_wr, .rd_idx(arch_rd_idx), .rd_data(arch_rd_data)
    );

    //////////////////////////////
    // outbound commit streams
    //////////////////////////////
    commit_fifo #(.payload_t(rob_pkg::free_reg_t)) free_q_i (
        .clk, .rstn, .push(free_push), .push_data_0(free_data_0),
        .push_data_1(free_data_1), .room(free_room),
        .req(free_req), .ack(free_ack), .data(free_reg)
    );

    commit_fifo #(.payload_t(rob_pkg::store_commit_t)) store_q_i (
        .clk, .rstn, .push(store_push), .push_data_0(store_data_0),
        .push_data_1(store_data_1), .room(store_room),
        .req(store_req), .ack(store_ack), .data(store_commit)
    );

endmodule

`default_nettype wire

//--- sources.f
+incdir+source
source/rob_pkg.sv
source/rob_ctrl.sv
source/rob_entry_array.sv
source/commit_fifo.sv
source/arch_reg_file.sv
source/rob_top.sv
dv/rob_sva.sv
dv/tb_rob.sv
